// File: Makefile
# Verilator build and run for the MIPS multicycle core

VERILATOR ?= verilator
TOP ?= mipsCoreTb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= TEST PASSED

SOURCES := $(wildcard rtl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+test
rtl/mipsPkg.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/mipsCore.sv
test/mipsCoreTb.sv

// File: test/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

localparam logic [1:0] NO_EVENT = 2'd0;
localparam logic [1:0] WB_EVENT = 2'd1;	// Register write
localparam logic [1:0] STORE_EVENT = 2'd2;	// Store on the bus
localparam int NUM_ENTRIES = 25;

typedef struct packed {
	logic [31:0] instr;
	logic [1:0] kind;
	logic [31:0] target;	// Register number or byte address
	mipsPkg::word_t value;
} entry_t;

// I-type word, op rs rt imm16
function automatic logic [31:0] iWord(input logic [5:0] op, input int rs, input int rt,
	input logic [15:0] imm);
	return {op, 5'(rs), 5'(rt), imm};
endfunction

// R-type word, opcode zero and shamt zero
function automatic logic [31:0] rWord(input logic [5:0] fn, input int rs, input int rt,
	input int rd);
	return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
endfunction

function automatic entry_t programEntry(input int idx);
	case (idx)
		0: return '{iWord(6'h08, 0, 1, 16'hfff6), WB_EVENT, 1, 32'hfffffff6};	// addi -10
		1: return '{iWord(6'h0d, 0, 2, 16'h8001), WB_EVENT, 2, 32'h00008001};	// ori
		2: return '{iWord(6'h0c, 1, 3, 16'hff0f), WB_EVENT, 3, 32'h0000ff06};	// andi
		3: return '{iWord(6'h0e, 1, 4, 16'h00ff), WB_EVENT, 4, 32'hffffff09};	// xori
		4: return '{iWord(6'h0f, 0, 5, 16'h1234), WB_EVENT, 5, 32'h12340000};	// lui
		5: return '{rWord(6'h20, 5, 2, 6), WB_EVENT, 6, 32'h12348001};	// add
		6: return '{rWord(6'h22, 2, 1, 7), WB_EVENT, 7, 32'h0000800b};	// sub r2 - r1
		7: return '{rWord(6'h24, 5, 6, 8), WB_EVENT, 8, 32'h12340000};	// and
		8: return '{rWord(6'h25, 3, 2, 9), WB_EVENT, 9, 32'h0000ff07};	// or
		9: return '{rWord(6'h27, 1, 2, 10), WB_EVENT, 10, 32'h00000008};	// nor
		10: return '{rWord(6'h26, 4, 1, 11), WB_EVENT, 11, 32'h000000ff};	// xor
		11: return '{rWord(6'h2a, 1, 2, 12), WB_EVENT, 12, 32'h00000001};	// slt, -10 < 0x8001
		12: return '{rWord(6'h2b, 1, 2, 13), WB_EVENT, 13, 32'h00000000};	// sltu, huge
		13: return '{iWord(6'h0a, 1, 14, 16'h0005), WB_EVENT, 14, 32'h00000001};	// slti
		14: return '{iWord(6'h0b, 1, 15, 16'hfff7), WB_EVENT, 15, 32'h00000001};	// sltiu
		15: return '{iWord(6'h08, 1, 0, 16'h0064), NO_EVENT, 0, 0};	// addi into r0
		16: return '{rWord(6'h20, 0, 7, 16), WB_EVENT, 16, 32'h0000800b};	// r0 + r7
		17: return '{iWord(6'h2b, 0, 6, 16'h0100), STORE_EVENT, 32'h100, 32'h12348001};	// sw
		18: return '{iWord(6'h23, 0, 17, 16'h0100), WB_EVENT, 17, 32'h12348001};	// lw
		19: return '{iWord(6'h08, 0, 18, 16'h0110), WB_EVENT, 18, 32'h00000110};	// base
		20: return '{iWord(6'h2b, 18, 4, 16'hfff8), STORE_EVENT, 32'h108, 32'hffffff09};
		21: return '{iWord(6'h23, 18, 19, 16'hfff8), WB_EVENT, 19, 32'hffffff09};	// lw -8
		22: return '{rWord(6'h21, 17, 19, 20), WB_EVENT, 20, 32'h12347f0a};	// addu
		23: return '{32'h00000000, NO_EVENT, 0, 0};	// All-zero word
		24: return '{rWord(6'h23, 0, 1, 21), WB_EVENT, 21, 32'h0000000a};	// subu 0 - r1
		default: return '{32'h00000000, NO_EVENT, 0, 0};
	endcase
endfunction

`endif

// File: test/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;

	localparam int ADDR_WIDTH = 9;
	localparam int MEM_BYTES = 1 << ADDR_WIDTH;
	localparam int TIMEOUT_CYCLES = 100;	// Per wait

	`include "programTable.svh"

	logic CLK;
	logic reset = 1'b1;
	logic memRequest;
	logic memAck = 1'b0;
	logic [ADDR_WIDTH-1:0] memAddr;
	mipsPkg::memCmd_t memCmd;
	mipsPkg::word_t memRdata = '0;
	mipsPkg::wb_t wb;

	logic [7:0] mem [MEM_BYTES];	// Byte array, big-endian words
	int waitLeft = -1;	// Ack delay countdown
	logic storeLogged = 1'b0;
	mipsPkg::wb_t wbQ [$];	// Observed register writes
	logic [ADDR_WIDTH-1:0] storeAddrQ [$];
	mipsPkg::word_t storeDataQ [$];
	int wbRead = 0;	// Read pointers into the queues
	int storeRead = 0;
	int errorCount = 0;
	int timeoutCount = 0;
	int checkCount = 0;

	mipsCore #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_mipsCore (
		.CLK(CLK),
		.reset(reset),
		.memRequest(memRequest),
		.memAck(memAck),
		.memAddr(memAddr),
		.memCmd(memCmd),
		.memRdata(memRdata),
		.wb(wb)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;	// 20 ns period
	end

	//////////////////////////////
	// Memory model
	//////////////////////////////
	task automatic writeWord(input int addr, input mipsPkg::word_t data);
		mem[addr] = data[31:24];	// MSB at lowest address
		mem[addr + 1] = data[23:16];
		mem[addr + 2] = data[15:8];
		mem[addr + 3] = data[7:0];
	endtask

	function automatic mipsPkg::word_t readWord(input int addr);
		return {mem[addr], mem[addr + 1], mem[addr + 2], mem[addr + 3]};
	endfunction

	initial begin
		entry_t loadEntry;
		void'($urandom(32'h7c16));	// Fixed ack delay sequence
		forever begin
			@(posedge CLK);
			if (reset) begin
				memAck <= 1'b0;
				waitLeft = -1;
				for (int b = 0; b < MEM_BYTES; b++) begin
					mem[b] = 8'h00;	// Data region and tail clear
				end
				for (int k = 0; k < NUM_ENTRIES; k++) begin
					loadEntry = programEntry(k);
					writeWord(4 * k, loadEntry.instr);
				end
			end else if (memAck) begin
				if (!memRequest) begin
					memAck <= 1'b0;	// Phase 4
				end
			end else if (memRequest) begin
				if (waitLeft < 0) begin
					waitLeft = int'($urandom % 4);	// 0 to 3 cycles
				end
				if (waitLeft == 0) begin
					if (memCmd.write) begin
						writeWord(int'(memAddr), memCmd.wdata);
					end else begin
						memRdata <= readWord(int'(memAddr));
					end
					memAck <= 1'b1;	// Phase 2
					waitLeft = -1;
				end else begin
					waitLeft--;
				end
			end
		end
	end

	// Bus and writeback monitor
	always @(posedge CLK) begin
		if (!reset) begin
			if (wb.valid) begin
				wbQ.push_back(wb);
			end
			if (memRequest && memCmd.write && !storeLogged) begin	// Once per request
				storeAddrQ.push_back(memAddr);
				storeDataQ.push_back(memCmd.wdata);
			end
			storeLogged = memRequest && memCmd.write;
		end
	end

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic checkWb(input mipsPkg::wb_t got, input mipsPkg::wb_t exp, input string what);
		checkCount++;
		if (got.valid !== exp.valid
			|| (exp.valid && (got.dest !== exp.dest || got.value !== exp.value))) begin
			errorCount++;
			$display("Error at %0t: %s wb {%0b, r%0d, %08h}, expected {%0b, r%0d, %08h}",
				$time, what, got.valid, got.dest, got.value, exp.valid, exp.dest, exp.value);
		end
	endtask

	task automatic checkStore(input logic [ADDR_WIDTH-1:0] gotAddr,
		input mipsPkg::word_t gotData, input logic [ADDR_WIDTH-1:0] expAddr,
		input mipsPkg::word_t expData, input string what);
		checkCount++;
		if (gotAddr !== expAddr || gotData !== expData) begin
			errorCount++;
			$display("Error at %0t: %s store %03h <- %08h, expected %03h <- %08h",
				$time, what, gotAddr, gotData, expAddr, expData);
		end
	endtask

	task automatic checkLevel(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic noExtraEvents(input string what);
		if (wbQ.size() != wbRead || storeAddrQ.size() != storeRead) begin
			errorCount++;
			$display("Unexpected register write or store seen %s", what);
		end
	endtask

	//////////////////////////////
	// Waits
	//////////////////////////////
	task automatic waitFetch(input logic [ADDR_WIDTH-1:0] addr, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
			@(negedge CLK);
			ok = memRequest && !memCmd.write && (memAddr == addr);
		end
		if (!ok) begin
			timeoutCount++;
			$display("Timed out waiting for the fetch from address %03h", addr);
		end
	endtask

	task automatic waitEvent(input bit wantStore, input int idx, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
			@(negedge CLK);
			ok = wantStore ? (storeAddrQ.size() > storeRead) : (wbQ.size() > wbRead);
		end
		if (!ok) begin
			timeoutCount++;
			$display("Timed out waiting for the result of entry %0d", idx);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		entry_t e;
		mipsPkg::wb_t expWb;
		mipsPkg::wb_t idleWb;
		int lowCycles;
		bit ok;
		bit running;
		idleWb = '0;
		running = 1'b1;
		for (int c = 0; c < 10; c++) begin	// Reset held 10 cycles
			@(negedge CLK);
			checkLevel(memRequest, 1'b0, "memRequest in reset");
			checkWb(wb, idleWb, "in reset");
		end
		@(posedge CLK);
		reset <= 1'b0;

		lowCycles = 0;	// Quiet cycles before first fetch
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
			@(negedge CLK);
			if (memRequest) begin
				ok = 1'b1;
			end else begin
				checkWb(wb, idleWb, "before first fetch");
				lowCycles++;
			end
		end
		if (!ok) begin
			timeoutCount++;
			running = 1'b0;
			$display("Timed out waiting for the first fetch request");
		end else if (lowCycles != 2) begin
			errorCount++;
			$display("Error at %0t: first fetch after %0d cycles, expected 2", $time, lowCycles);
		end

		for (int i = 0; i < NUM_ENTRIES && running; i++) begin
			e = programEntry(i);
			case (e.kind)
				WB_EVENT: begin
					waitEvent(1'b0, i, ok);
					if (ok) begin
						expWb = '{1'b1, mipsPkg::regIdx_t'(e.target), e.value};
						checkWb(wbQ[wbRead], expWb, $sformatf("entry %0d", i));
						wbRead++;
					end
				end
				STORE_EVENT: begin
					waitEvent(1'b1, i, ok);
					if (ok) begin
						checkStore(storeAddrQ[storeRead], storeDataQ[storeRead],
							ADDR_WIDTH'(e.target), e.value, $sformatf("entry %0d", i));
						storeRead++;
					end
				end
				default: begin	// No-op, quiet until next fetch
					waitFetch(ADDR_WIDTH'(4 * (i + 1)), ok);
					if (ok) begin
						noExtraEvents($sformatf("during entry %0d", i));
					end
				end
			endcase
			running = ok;
		end

		if (running) begin	// Zero words past the program
			waitFetch(ADDR_WIDTH'(4 * (NUM_ENTRIES + 2)), ok);
			running = ok;
			noExtraEvents("after the program");
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
		if (running && errorCount == 0 && timeoutCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
	parameter int ADDR_WIDTH = 9	// Byte address bits
) (
	input logic CLK,
	input logic reset,
	output logic memRequest,	// Four-phase req
	input logic memAck,	// Four-phase ack
	output logic [ADDR_WIDTH-1:0] memAddr,
	output mipsPkg::memCmd_t memCmd,
	input mipsPkg::word_t memRdata,
	output mipsPkg::wb_t wb	// Register write report
);

	mipsPkg::ctrl_t ctrl;	// Control word
	mipsPkg::opcode_e opcode;	// From IR
	mipsPkg::funct_e funct;	// From IR

	//////////////////////////////
	// Control
	//////////////////////////////
	controlUnit i_controlUnit (
		.CLK(CLK),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.memAck(memAck),
		.memRequest(memRequest),
		.ctrl(ctrl)
	);

	//////////////////////////////
	// Datapath
	//////////////////////////////
	datapath #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_datapath (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memCmd(memCmd),
		.opcode(opcode),
		.funct(funct),
		.wb(wb)
	);

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath #(
	parameter int ADDR_WIDTH = 9
) (
	input logic CLK,
	input logic reset,
	input mipsPkg::ctrl_t ctrl,
	input mipsPkg::word_t memRdata,
	output logic [ADDR_WIDTH-1:0] memAddr,
	output mipsPkg::memCmd_t memCmd,
	output mipsPkg::opcode_e opcode,
	output mipsPkg::funct_e funct,
	output mipsPkg::wb_t wb
);

	logic [ADDR_WIDTH-1:0] pc;	// Byte address of next fetch
	logic [ADDR_WIDTH-1:0] mar;
	mipsPkg::word_t ir;
	mipsPkg::word_t mdr;

	mipsPkg::regIdx_t rs, rt, rd;	// IR fields
	logic [15:0] imm16;
	logic zeroExt;	// Logical immediates
	mipsPkg::word_t immExt;

	mipsPkg::word_t rDataA, rDataB;
	mipsPkg::word_t aluB, aluY;
	mipsPkg::regIdx_t wAddr;
	mipsPkg::word_t wData;

	//////////////////////////////
	// Instruction fields
	//////////////////////////////
	assign opcode = mipsPkg::opcode_e'(ir[31:26]);
	assign funct = mipsPkg::funct_e'(ir[5:0]);
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign imm16 = ir[15:0];

	assign zeroExt = (opcode == mipsPkg::OP_ANDI) || (opcode == mipsPkg::OP_ORI)
		|| (opcode == mipsPkg::OP_XORI);
	assign immExt = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	//////////////////////////////
	// PC, IR, MAR, MDR
	//////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
			mar <= '0;
			mdr <= '0;
		end else begin
			if (ctrl.pcLd) begin
				pc <= pc + ADDR_WIDTH'(4);	// Next word
			end
			if (ctrl.irLd) begin
				ir <= memRdata;
			end
			if (ctrl.marLd) begin	// Low address bits only
				mar <= ctrl.marSrcAlu ? aluY[ADDR_WIDTH-1:0] : pc;
			end
			if (ctrl.mdrLd) begin
				mdr <= ctrl.mdrSrcMem ? memRdata : rDataB;
			end
		end
	end

	assign memAddr = mar;
	assign memCmd.write = ctrl.memWrite;
	assign memCmd.wdata = mdr;	// Store data

	//////////////////////////////
	// Operands and write-back
	//////////////////////////////
	assign aluB = ctrl.aluSrcImm ? immExt : rDataB;
	assign wAddr = ctrl.regDstRt ? rt : rd;
	assign wData = ctrl.regInSel ? mdr : aluY;	// Load data or ALU result

	registerFile i_registerFile (
		.CLK(CLK),
		.reset(reset),
		.we(ctrl.regW),
		.wAddr(wAddr),
		.wData(wData),
		.rAddrA(rs),
		.rAddrB(rt),
		.rDataA(rDataA),
		.rDataB(rDataB)
	);

	alu i_alu (
		.aluSel(ctrl.aluSel),
		.funct(funct),
		.a(rDataA),
		.b(aluB),
		.y(aluY)
	);

	assign wb.valid = ctrl.regW && (wAddr != '0);	// R0 writes not reported
	assign wb.dest = wAddr;
	assign wb.value = wData;

	// Word aligned at every fetch ack, load ack and store
	assert property (@(posedge CLK) disable iff (reset)
		(ctrl.irLd || ctrl.memWrite || (ctrl.mdrLd && ctrl.mdrSrcMem)) |-> (mar[1:0] == 2'b00))
		else $error("Unaligned MAR during memory access");

endmodule

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input logic CLK,
	input logic reset,
	input mipsPkg::opcode_e opcode,
	input mipsPkg::funct_e funct,
	input logic memAck,
	output logic memRequest,
	output mipsPkg::ctrl_t ctrl
);

	mipsPkg::state_e state, nextState;
	logic functOk;	// Funct in the kept set
	mipsPkg::aluSel_e immSel;	// ALU request for immediates

	always_comb begin
		case (funct)
			mipsPkg::FN_ADD, mipsPkg::FN_ADDU, mipsPkg::FN_SUB, mipsPkg::FN_SUBU,
			mipsPkg::FN_AND, mipsPkg::FN_OR, mipsPkg::FN_XOR, mipsPkg::FN_NOR,
			mipsPkg::FN_SLT, mipsPkg::FN_SLTU: functOk = 1'b1;
			default: functOk = 1'b0;	// Completes as no-op
		endcase
	end

	always_comb begin
		case (opcode)
			mipsPkg::OP_SLTI: immSel = mipsPkg::SEL_SLT;
			mipsPkg::OP_SLTIU: immSel = mipsPkg::SEL_SLTU;
			mipsPkg::OP_ANDI: immSel = mipsPkg::SEL_AND;
			mipsPkg::OP_ORI: immSel = mipsPkg::SEL_OR;
			mipsPkg::OP_XORI: immSel = mipsPkg::SEL_XOR;
			mipsPkg::OP_LUI: immSel = mipsPkg::SEL_LUI;
			default: immSel = mipsPkg::SEL_ADD;	// ADDI, ADDIU
		endcase
	end

	//////////////////////////////
	// State register
	//////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= mipsPkg::S_IDLE;
		end else begin
			state <= nextState;
		end
	end

	//////////////////////////////
	// Next state
	//////////////////////////////
	always_comb begin
		nextState = state;	// WAIT states hold here
		case (state)
			mipsPkg::S_IDLE: nextState = mipsPkg::S_FETCH_REQ;
			mipsPkg::S_FETCH_REQ: nextState = mipsPkg::S_FETCH_WAIT;	// Ack already low
			mipsPkg::S_FETCH_WAIT: begin
				if (memAck) begin
					nextState = mipsPkg::S_DECODE;
				end
			end
			mipsPkg::S_DECODE: begin
				case (opcode)
					mipsPkg::OP_RTYPE: begin
						nextState = functOk ? mipsPkg::S_EXEC_R : mipsPkg::S_RELEASE;
					end
					mipsPkg::OP_ADDI, mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU,
					mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI,
					mipsPkg::OP_LUI: nextState = mipsPkg::S_EXEC_I;
					mipsPkg::OP_LW, mipsPkg::OP_SW: nextState = mipsPkg::S_MEM_ADDR;
					default: nextState = mipsPkg::S_RELEASE;	// Unknown opcode
				endcase
			end
			mipsPkg::S_EXEC_R, mipsPkg::S_EXEC_I: nextState = mipsPkg::S_RELEASE;
			mipsPkg::S_MEM_ADDR: begin
				if (opcode == mipsPkg::OP_SW) begin
					nextState = mipsPkg::S_STORE_REQ;
				end else begin
					nextState = mipsPkg::S_LOAD_REQ;
				end
			end
			mipsPkg::S_LOAD_REQ: begin
				if (!memAck) begin	// Fetch ack gone
					nextState = mipsPkg::S_LOAD_WAIT;
				end
			end
			mipsPkg::S_LOAD_WAIT: begin
				if (memAck) begin
					nextState = mipsPkg::S_LOAD_WB;
				end
			end
			mipsPkg::S_LOAD_WB: nextState = mipsPkg::S_RELEASE;
			mipsPkg::S_STORE_REQ: begin
				if (!memAck) begin
					nextState = mipsPkg::S_STORE_WAIT;
				end
			end
			mipsPkg::S_STORE_WAIT: begin
				if (memAck) begin
					nextState = mipsPkg::S_RELEASE;
				end
			end
			mipsPkg::S_RELEASE: begin
				if (!memAck) begin	// Last access finished
					nextState = mipsPkg::S_FETCH_REQ;
				end
			end
			default: nextState = mipsPkg::S_IDLE;
		endcase
	end

	//////////////////////////////
	// Control word encoder
	//////////////////////////////
	always_comb begin
		ctrl = '0;	// IDLE, DECODE, RELEASE
		case (state)
			mipsPkg::S_FETCH_REQ: ctrl.marLd = 1'b1;	// MAR <= PC
			mipsPkg::S_FETCH_WAIT: begin
				ctrl.irLd = memAck;
				ctrl.pcLd = memAck;
			end
			mipsPkg::S_EXEC_R: begin
				ctrl.regW = 1'b1;
				ctrl.aluSel = mipsPkg::SEL_FUNCT;
			end
			mipsPkg::S_EXEC_I: begin
				ctrl.regW = 1'b1;
				ctrl.regDstRt = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluSel = immSel;
			end
			mipsPkg::S_MEM_ADDR: begin	// rs + imm into MAR
				ctrl.marLd = 1'b1;
				ctrl.marSrcAlu = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluSel = mipsPkg::SEL_ADD;
			end
			mipsPkg::S_LOAD_WAIT: begin
				ctrl.mdrLd = memAck;
				ctrl.mdrSrcMem = 1'b1;
			end
			mipsPkg::S_LOAD_WB: begin
				ctrl.regW = 1'b1;
				ctrl.regInSel = 1'b1;
				ctrl.regDstRt = 1'b1;
			end
			mipsPkg::S_STORE_REQ: begin	// rt into MDR
				ctrl.mdrLd = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsPkg::S_STORE_WAIT: ctrl.memWrite = 1'b1;
			default: ;
		endcase
	end

	assign memRequest = (state == mipsPkg::S_FETCH_WAIT) || (state == mipsPkg::S_LOAD_WAIT)
		|| (state == mipsPkg::S_STORE_WAIT);

	// Four-phase rule, request only after the previous ack dropped
	assert property (@(posedge CLK) disable iff (reset) $rose(memRequest) |-> !memAck)
		else $error("memRequest raised while memAck high");

	assert property (@(posedge CLK) disable iff (reset)
		state inside {[mipsPkg::S_IDLE:mipsPkg::S_RELEASE]})
		else $error("Illegal FSM state");

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input mipsPkg::aluSel_e aluSel,
	input mipsPkg::funct_e funct,
	input mipsPkg::word_t a,
	input mipsPkg::word_t b,
	output mipsPkg::word_t y
);

	mipsPkg::aluOp_e op;	// Decoded operation

	//////////////////////////////
	// ALU control
	//////////////////////////////
	always_comb begin
		case (aluSel)
			mipsPkg::SEL_FUNCT: begin	// R-type
				case (funct)
					mipsPkg::FN_ADD, mipsPkg::FN_ADDU: op = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUB, mipsPkg::FN_SUBU: op = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: op = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: op = mipsPkg::ALU_OR;
					mipsPkg::FN_NOR: op = mipsPkg::ALU_NOR;
					mipsPkg::FN_XOR: op = mipsPkg::ALU_XOR;
					mipsPkg::FN_SLT: op = mipsPkg::ALU_SLT;
					mipsPkg::FN_SLTU: op = mipsPkg::ALU_SLTU;
					default: op = mipsPkg::ALU_NONE;
				endcase
			end
			mipsPkg::SEL_ADD: op = mipsPkg::ALU_ADD;	// Also address calc
			mipsPkg::SEL_SLT: op = mipsPkg::ALU_SLT;
			mipsPkg::SEL_SLTU: op = mipsPkg::ALU_SLTU;
			mipsPkg::SEL_AND: op = mipsPkg::ALU_AND;
			mipsPkg::SEL_OR: op = mipsPkg::ALU_OR;
			mipsPkg::SEL_XOR: op = mipsPkg::ALU_XOR;
			mipsPkg::SEL_LUI: op = mipsPkg::ALU_LUI;
			default: op = mipsPkg::ALU_NONE;
		endcase
	end

	//////////////////////////////
	// Arithmetic and logic
	//////////////////////////////
	always_comb begin
		case (op)
			mipsPkg::ALU_ADD: y = a + b;	// Wraps, no overflow trap
			mipsPkg::ALU_SUB: y = a - b;
			mipsPkg::ALU_AND: y = a & b;
			mipsPkg::ALU_OR: y = a | b;
			mipsPkg::ALU_NOR: y = ~(a | b);
			mipsPkg::ALU_XOR: y = a ^ b;
			mipsPkg::ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};	// Signed compare
			mipsPkg::ALU_SLTU: y = {31'b0, a < b};	// Unsigned compare
			mipsPkg::ALU_LUI: y = {b[15:0], 16'h0000};	// Imm to upper half
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input logic CLK,
	input logic reset,
	input logic we,
	input mipsPkg::regIdx_t wAddr,
	input mipsPkg::word_t wData,
	input mipsPkg::regIdx_t rAddrA,
	input mipsPkg::regIdx_t rAddrB,
	output mipsPkg::word_t rDataA,
	output mipsPkg::word_t rDataB
);

	mipsPkg::word_t regs [32];	// R0 never written

	//////////////////////////////
	// Write port
	//////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;	// All clear
			end
		end else if (we && (wAddr != '0)) begin	// Drop R0 writes
			regs[wAddr] <= wData;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////
	assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];	// R0 reads zero
	assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	typedef logic [31:0] word_t;	// Data word
	typedef logic [4:0] regIdx_t;	// Register number

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,	// Operation in funct
		OP_ADDI = 6'h08,
		OP_ADDIU = 6'h09,
		OP_SLTI = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ANDI = 6'h0c,	// Zero-extended imm
		OP_ORI = 6'h0d,	// Zero-extended imm
		OP_XORI = 6'h0e,	// Zero-extended imm
		OP_LUI = 6'h0f,
		OP_LW = 6'h23,
		OP_SW = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_ADDU = 6'h21,	// No overflow trap, same as ADD here
		FN_SUB = 6'h22,
		FN_SUBU = 6'h23,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_XOR = 6'h26,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOR,
		ALU_XOR, ALU_SLT, ALU_SLTU, ALU_LUI,
		ALU_NONE = 4'hf	// Unknown funct
	} aluOp_e;

	typedef enum logic [2:0] {
		SEL_FUNCT, SEL_ADD, SEL_SLT, SEL_SLTU,
		SEL_AND, SEL_OR, SEL_XOR, SEL_LUI
	} aluSel_e;

	typedef enum logic [3:0] {
		S_IDLE, S_FETCH_REQ, S_FETCH_WAIT, S_DECODE,
		S_EXEC_R, S_EXEC_I, S_MEM_ADDR, S_LOAD_REQ,
		S_LOAD_WAIT, S_LOAD_WB, S_STORE_REQ, S_STORE_WAIT,
		S_RELEASE
	} state_e;

	//////////////////////////////
	// Control word
	//////////////////////////////
	typedef struct packed {
		logic pcLd;	// PC += 4
		logic irLd;	// IR <= memRdata
		logic marLd;
		logic marSrcAlu;	// MAR from ALU, else from PC
		logic mdrLd;
		logic mdrSrcMem;	// MDR from memory, else from rt
		logic memWrite;	// Store in progress
		logic regW;
		logic regInSel;	// 1 = MDR, 0 = ALU result
		logic regDstRt;	// Dest rt, else rd
		logic aluSrcImm;	// B operand is extended imm
		aluSel_e aluSel;
	} ctrl_t;

	typedef struct packed {
		logic write;	// 1 = store
		word_t wdata;
	} memCmd_t;

	typedef struct packed {
		logic valid;	// One pulse per register write
		regIdx_t dest;
		word_t value;
	} wb_t;

endpackage

`default_nettype wire
